//--- common/mshr_params.svh
`ifndef MSHR_PARAMS_SVH
`define MSHR_PARAMS_SVH

// number of entries in the miss ring
`define MSHR_DEPTH 8

// misses accepted from the cache per cycle
`define MISS_LANES 2

// line address width
`define ADDR_WIDTH 32

// one cache line of data
`define LINE_WIDTH 64

// memory transaction tag where zero means no response
`define TAG_WIDTH 4

`endif

//--- common/mshr_pkg.sv
`include "mshr_params.svh"

package mshr_pkg;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  typedef logic [`LINE_WIDTH-1:0] line_t;

  typedef logic [`TAG_WIDTH-1:0] mem_tag_t;

  // index into the entry ring
  typedef logic [$clog2(`MSHR_DEPTH)-1:0] entry_ptr_t;

  // memory bus commands
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

  // per-entry lifecycle
  typedef enum logic [1:0] {
    EMPTY    = 2'h0,
    WAITING  = 2'h1,
    INFLIGHT = 2'h2,
    DONE     = 2'h3
  } entry_state_t;

endpackage

//--- common/mshr_entry_if.sv
`timescale 1ns/10ps

`include "mshr_params.svh"

interface mshr_entry_if;

  // new miss from the allocator
  logic                   alloc;
  mshr_pkg::addr_t        alloc_addr;
  mshr_pkg::line_t        alloc_data;
  mshr_pkg::bus_cmd_t     alloc_cmd;

  // request accepted by memory
  logic                   issue;
  mshr_pkg::mem_tag_t     issue_tag;

  // entry leaves the ring
  logic                   retire;

  // entry contents
  mshr_pkg::entry_state_t state;
  mshr_pkg::bus_cmd_t     cmd;
  mshr_pkg::addr_t        addr;
  mshr_pkg::line_t        data;
  logic                   match;

  modport entry (
    input  alloc, alloc_addr, alloc_data, alloc_cmd,
    input  issue, issue_tag, retire,
    output state, cmd, addr, data, match
  );

  modport feeder (
    output alloc, alloc_addr, alloc_data, alloc_cmd,
    input  state, match
  );

  modport drainer (
    output issue, issue_tag, retire,
    input  state, cmd, addr, data
  );

endinterface

//--- design/mshr_alloc.sv
`timescale 1ns/10ps

`include "mshr_params.svh"

module mshr_alloc (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [`MISS_LANES-1:0]                 miss_valid,
  input  mshr_pkg::addr_t [`MISS_LANES-1:0]      miss_addr,
  input  mshr_pkg::line_t [`MISS_LANES-1:0]      miss_data,
  input  mshr_pkg::bus_cmd_t [`MISS_LANES-1:0]   miss_cmd,
  output logic                                   alloc_ready,
  output logic                                   mshr_empty,
  output logic                                   search_hit,
  mshr_entry_if.feeder                           entries [`MSHR_DEPTH]
);

  mshr_pkg::entry_ptr_t   tail;
  mshr_pkg::entry_ptr_t   alloc_count;
  mshr_pkg::entry_ptr_t   lane_slot [`MISS_LANES];
  logic [`MISS_LANES-1:0] lane_take;

  mshr_pkg::entry_state_t state_vec [`MSHR_DEPTH];
  logic [`MSHR_DEPTH-1:0] match_vec;

  // room for a full set of lanes starting at the tail
  always_comb begin
    alloc_ready = 1'b1;
    for (int l = 0; l < `MISS_LANES; l++) begin
      if (state_vec[mshr_pkg::entry_ptr_t'(tail + l)] != mshr_pkg::EMPTY) begin
        alloc_ready = 1'b0;
      end
    end
  end

  // compact valid lanes into consecutive slots with lane 0 first
  always_comb begin
    mshr_pkg::entry_ptr_t offset;
    offset = '0;
    for (int l = 0; l < `MISS_LANES; l++) begin
      lane_take[l] = miss_valid[l] & alloc_ready;
      lane_slot[l] = tail + offset;
      if (lane_take[l]) begin
        offset = offset + 1'b1;
      end
    end
    alloc_count = offset;
  end

  genvar i;
  generate
    for (i = 0; i < `MSHR_DEPTH; i++) begin : g_feed
      always_comb begin
        entries[i].alloc      = 1'b0;
        entries[i].alloc_addr = miss_addr[0];
        entries[i].alloc_data = miss_data[0];
        entries[i].alloc_cmd  = miss_cmd[0];
        for (int l = 0; l < `MISS_LANES; l++) begin
          if (lane_take[l] && lane_slot[l] == mshr_pkg::entry_ptr_t'(i)) begin
            entries[i].alloc      = 1'b1;
            entries[i].alloc_addr = miss_addr[l];
            entries[i].alloc_data = miss_data[l];
            entries[i].alloc_cmd  = miss_cmd[l];
          end
        end
      end

      assign state_vec[i] = entries[i].state;
      assign match_vec[i] = entries[i].match;
    end
  endgenerate

  always_comb begin
    mshr_empty = 1'b1;
    for (int e = 0; e < `MSHR_DEPTH; e++) begin
      if (state_vec[e] != mshr_pkg::EMPTY) begin
        mshr_empty = 1'b0;
      end
    end
  end

  assign search_hit = |match_vec;

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else begin
      tail <= tail + alloc_count;
    end
  end

  // the cache must hold off while the ring is short of space
  miss_only_when_ready: assert property (
    @(posedge clock) disable iff (reset)
    (|miss_valid) |-> alloc_ready
  ) else $error("miss presented while alloc_ready is low");

endmodule

//--- design/mshr_entry.sv
`timescale 1ns/10ps

`include "mshr_params.svh"

module mshr_entry (
  input  logic               clock,
  input  logic               reset,
  input  mshr_pkg::mem_tag_t mem2proc_tag,
  input  mshr_pkg::line_t    mem2proc_data,
  input  mshr_pkg::addr_t    search_addr,
  mshr_entry_if.entry        port
);

  mshr_pkg::entry_state_t state;
  mshr_pkg::bus_cmd_t     line_cmd;
  mshr_pkg::addr_t        line_addr;
  mshr_pkg::line_t        line_data;
  mshr_pkg::mem_tag_t     mem_tag;
  logic                   tag_hit;

  // returned line belongs to this entry
  assign tag_hit = (state == mshr_pkg::INFLIGHT) &&
                   (mem2proc_tag != '0) &&
                   (mem2proc_tag == mem_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mshr_pkg::EMPTY;
    end else begin
      case (state)
        mshr_pkg::EMPTY: begin
          if (port.alloc) begin
            state <= mshr_pkg::WAITING;
          end
        end
        mshr_pkg::WAITING: begin
          // evictions finish as soon as memory takes them
          if (port.issue) begin
            state <= (line_cmd == mshr_pkg::BUS_LOAD) ? mshr_pkg::INFLIGHT : mshr_pkg::DONE;
          end
        end
        mshr_pkg::INFLIGHT: begin
          if (tag_hit) begin
            state <= mshr_pkg::DONE;
          end
        end
        mshr_pkg::DONE: begin
          if (port.retire) begin
            state <= mshr_pkg::EMPTY;
          end
        end
        default: state <= mshr_pkg::EMPTY;
      endcase
    end
  end

  // miss payload and returned line
  always_ff @(posedge clock) begin
    if (port.alloc) begin
      line_cmd  <= port.alloc_cmd;
      line_addr <= port.alloc_addr;
      line_data <= port.alloc_data;
    end
    if (port.issue) begin
      mem_tag <= port.issue_tag;
    end
    if (tag_hit) begin
      line_data <= mem2proc_data;
    end
  end

  assign port.state = state;
  assign port.cmd   = line_cmd;
  assign port.addr  = line_addr;
  assign port.data  = line_data;
  assign port.match = (state != mshr_pkg::EMPTY) && (line_addr == search_addr);

  // allocator and dispatcher only touch an entry in the right state
  alloc_into_empty: assert property (
    @(posedge clock) disable iff (reset)
    port.alloc |-> state == mshr_pkg::EMPTY
  ) else $error("alloc into an occupied entry");

  issue_from_waiting: assert property (
    @(posedge clock) disable iff (reset)
    port.issue |-> state == mshr_pkg::WAITING
  ) else $error("issue to an entry that is not waiting");

endmodule

//--- design/mshr_dispatch.sv
`timescale 1ns/10ps

`include "mshr_params.svh"

module mshr_dispatch (
  input  logic               clock,
  input  logic               reset,
  output mshr_pkg::bus_cmd_t proc2mem_command,
  output mshr_pkg::addr_t    proc2mem_addr,
  output mshr_pkg::line_t    proc2mem_data,
  input  mshr_pkg::mem_tag_t mem2proc_response,
  output logic               fill_valid,
  output mshr_pkg::addr_t    fill_addr,
  output mshr_pkg::line_t    fill_data,
  input  logic               fill_ack,
  mshr_entry_if.drainer      entries [`MSHR_DEPTH]
);

  mshr_pkg::entry_ptr_t   issue_head;
  mshr_pkg::entry_ptr_t   retire_head;

  mshr_pkg::entry_state_t state_vec [`MSHR_DEPTH];
  mshr_pkg::bus_cmd_t     cmd_vec [`MSHR_DEPTH];
  mshr_pkg::addr_t        addr_vec [`MSHR_DEPTH];
  mshr_pkg::line_t        data_vec [`MSHR_DEPTH];

  logic                   head_waiting;
  logic                   accepted;
  logic                   retire_done;
  logic                   retire_is_load;
  logic                   retire_now;

  genvar i;
  generate
    for (i = 0; i < `MSHR_DEPTH; i++) begin : g_drain
      assign state_vec[i] = entries[i].state;
      assign cmd_vec[i]   = entries[i].cmd;
      assign addr_vec[i]  = entries[i].addr;
      assign data_vec[i]  = entries[i].data;

      assign entries[i].issue     = accepted && (issue_head == mshr_pkg::entry_ptr_t'(i));
      assign entries[i].issue_tag = mem2proc_response;
      assign entries[i].retire    = retire_now && (retire_head == mshr_pkg::entry_ptr_t'(i));
    end
  endgenerate

  // oldest unissued miss drives the request
  assign head_waiting     = (state_vec[issue_head] == mshr_pkg::WAITING);
  assign proc2mem_command = head_waiting ? cmd_vec[issue_head] : mshr_pkg::BUS_NONE;
  assign proc2mem_addr    = addr_vec[issue_head];
  assign proc2mem_data    = data_vec[issue_head];

  // nonzero response is the grant
  assign accepted = head_waiting && (mem2proc_response != '0);

  // retire side stays in allocation order
  assign retire_done    = (state_vec[retire_head] == mshr_pkg::DONE);
  assign retire_is_load = (cmd_vec[retire_head] == mshr_pkg::BUS_LOAD);

  assign fill_valid = retire_done && retire_is_load;
  assign fill_addr  = addr_vec[retire_head];
  assign fill_data  = data_vec[retire_head];

  // stores drop out without a cache handshake
  assign retire_now = retire_done && (!retire_is_load || fill_ack);

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_head  <= '0;
      retire_head <= '0;
    end else begin
      if (accepted) begin
        issue_head <= issue_head + 1'b1;
      end
      if (retire_now) begin
        retire_head <= retire_head + 1'b1;
      end
    end
  end

  // stalled request must not change under back-pressure
  request_held: assert property (
    @(posedge clock) disable iff (reset)
    (proc2mem_command != mshr_pkg::BUS_NONE && mem2proc_response == '0) |=>
      ($stable(proc2mem_command) && $stable(proc2mem_addr) && $stable(proc2mem_data))
  ) else $error("memory request changed while stalled");

  // fill stays up with the same line until the cache takes it
  fill_held: assert property (
    @(posedge clock) disable iff (reset)
    (fill_valid && !fill_ack) |=>
      (fill_valid && $stable(fill_addr) && $stable(fill_data))
  ) else $error("fill dropped before fill_ack");

endmodule

//--- design/mshr_top.sv
`timescale 1ns/10ps

`include "mshr_params.svh"

module mshr_top (
  input  logic                                   clock,
  input  logic                                   reset,

  // misses from the cache
  input  logic [`MISS_LANES-1:0]                 miss_valid,
  input  mshr_pkg::addr_t [`MISS_LANES-1:0]      miss_addr,
  input  mshr_pkg::line_t [`MISS_LANES-1:0]      miss_data,
  input  mshr_pkg::bus_cmd_t [`MISS_LANES-1:0]   miss_cmd,
  output logic                                   alloc_ready,
  output logic                                   mshr_empty,

  // pending address lookup
  input  mshr_pkg::addr_t                        search_addr,
  output logic                                   search_hit,

  // memory request side
  output mshr_pkg::bus_cmd_t                     proc2mem_command,
  output mshr_pkg::addr_t                        proc2mem_addr,
  output mshr_pkg::line_t                        proc2mem_data,
  input  mshr_pkg::mem_tag_t                     mem2proc_response,

  // memory return side
  input  mshr_pkg::mem_tag_t                     mem2proc_tag,
  input  mshr_pkg::line_t                        mem2proc_data,

  // line fill back to the cache
  output logic                                   fill_valid,
  output mshr_pkg::addr_t                        fill_addr,
  output mshr_pkg::line_t                        fill_data,
  input  logic                                   fill_ack
);

  // one bundle per ring entry
  mshr_entry_if entry_bus [`MSHR_DEPTH] ();

  mshr_alloc u_alloc (
    .clock       (clock),
    .reset       (reset),
    .miss_valid  (miss_valid),
    .miss_addr   (miss_addr),
    .miss_data   (miss_data),
    .miss_cmd    (miss_cmd),
    .alloc_ready (alloc_ready),
    .mshr_empty  (mshr_empty),
    .search_hit  (search_hit),
    .entries     (entry_bus)
  );

  genvar i;
  generate
    for (i = 0; i < `MSHR_DEPTH; i++) begin : g_entry
      mshr_entry u_entry (
        .clock         (clock),
        .reset         (reset),
        .mem2proc_tag  (mem2proc_tag),
        .mem2proc_data (mem2proc_data),
        .search_addr   (search_addr),
        .port          (entry_bus[i])
      );
    end
  endgenerate

  mshr_dispatch u_dispatch (
    .clock             (clock),
    .reset             (reset),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .fill_valid        (fill_valid),
    .fill_addr         (fill_addr),
    .fill_data         (fill_data),
    .fill_ack          (fill_ack),
    .entries           (entry_bus)
  );

endmodule

//--- testbench/mshr_tests.svh
`ifndef MSHR_TESTS_SVH
`define MSHR_TESTS_SVH

// memory model and cache side helpers

function automatic mshr_pkg::line_t random_line();
  return {$urandom, $urandom};
endfunction

task automatic send_misses(input logic [1:0] valid,
                           input mshr_pkg::addr_t a0, input mshr_pkg::line_t d0,
                           input mshr_pkg::bus_cmd_t c0,
                           input mshr_pkg::addr_t a1, input mshr_pkg::line_t d1,
                           input mshr_pkg::bus_cmd_t c1);
  wait_alloc_ready();
  miss_valid = valid;
  miss_addr  = {a1, a0};
  miss_data  = {d1, d0};
  miss_cmd   = {c1, c0};
  @(negedge clock);
  miss_valid = '0;
endtask

// checks the request, holds it off for stall cycles, then grants it
task automatic grant_request(input mshr_pkg::bus_cmd_t cmd, input mshr_pkg::addr_t addr,
                             input mshr_pkg::line_t data, input mshr_pkg::mem_tag_t tag,
                             input int stall);
  wait_command();
  for (int s = 0; s <= stall; s++) begin
    if (s > 0) @(negedge clock);
    compare_cmd("proc2mem_command", proc2mem_command, cmd);
    compare_addr("proc2mem_addr", proc2mem_addr, addr);
    compare_line("proc2mem_data", proc2mem_data, data);
  end
  mem2proc_response = tag;
  @(negedge clock);
  mem2proc_response = '0;
endtask

task automatic return_line(input mshr_pkg::mem_tag_t tag, input mshr_pkg::line_t data);
  mem2proc_tag  = tag;
  mem2proc_data = data;
  @(negedge clock);
  mem2proc_tag  = '0;
endtask

// withholds fill_ack for hold cycles before taking the line
task automatic expect_fill(input mshr_pkg::addr_t addr, input mshr_pkg::line_t data,
                           input int hold);
  wait_fill();
  for (int s = 0; s <= hold; s++) begin
    if (s > 0) @(negedge clock);
    compare_bit("fill_valid", fill_valid, 1'b1);
    compare_addr("fill_addr", fill_addr, addr);
    compare_line("fill_data", fill_data, data);
  end
  fill_ack = 1'b1;
  @(negedge clock);
  fill_ack = 1'b0;
endtask

task automatic probe_lookup(input mshr_pkg::addr_t addr, input logic exp);
  search_addr = addr;
  #1;
  compare_bit("search_hit", search_hit, exp);
  @(negedge clock);
endtask

// directed tests

task automatic check_reset_state();
  compare_bit("alloc_ready", alloc_ready, 1'b1);
  compare_bit("mshr_empty", mshr_empty, 1'b1);
  compare_bit("fill_valid", fill_valid, 1'b0);
  compare_cmd("proc2mem_command", proc2mem_command, mshr_pkg::BUS_NONE);
endtask

task automatic single_load_test();
  mshr_pkg::addr_t a;
  mshr_pkg::line_t d;
  mshr_pkg::line_t l;
  a = $urandom;
  d = random_line();
  l = random_line();
  send_misses(2'b01, a, d, mshr_pkg::BUS_LOAD, '0, '0, mshr_pkg::BUS_NONE);
  compare_bit("mshr_empty", mshr_empty, 1'b0);
  grant_request(mshr_pkg::BUS_LOAD, a, d, 4'h3, 0);
  compare_cmd("proc2mem_command", proc2mem_command, mshr_pkg::BUS_NONE);
  return_line(4'h3, l);
  expect_fill(a, l, 2);
  wait_empty();
endtask

task automatic lane_order_test();
  mshr_pkg::addr_t a [3];
  mshr_pkg::line_t d [3];
  mshr_pkg::line_t l [3];
  for (int i = 0; i < 3; i++) begin
    a[i] = $urandom;
    d[i] = random_line();
    l[i] = random_line();
  end
  send_misses(2'b11, a[0], d[0], mshr_pkg::BUS_LOAD, a[1], d[1], mshr_pkg::BUS_LOAD);
  send_misses(2'b10, '0, '0, mshr_pkg::BUS_NONE, a[2], d[2], mshr_pkg::BUS_LOAD);
  // back-pressure on the first request
  grant_request(mshr_pkg::BUS_LOAD, a[0], d[0], 4'h1, 3);
  grant_request(mshr_pkg::BUS_LOAD, a[1], d[1], 4'h2, 0);
  grant_request(mshr_pkg::BUS_LOAD, a[2], d[2], 4'h3, 1);
  for (int i = 0; i < 3; i++) begin
    return_line(mshr_pkg::mem_tag_t'(i + 1), l[i]);
  end
  for (int i = 0; i < 3; i++) begin
    expect_fill(a[i], l[i], 0);
  end
  wait_empty();
endtask

task automatic eviction_test();
  mshr_pkg::addr_t a;
  mshr_pkg::line_t d;
  a = $urandom;
  d = random_line();
  send_misses(2'b01, a, d, mshr_pkg::BUS_STORE, '0, '0, mshr_pkg::BUS_NONE);
  grant_request(mshr_pkg::BUS_STORE, a, d, 4'h5, 2);
  compare_bit("fill_valid", fill_valid, 1'b0);
  wait_empty();
  compare_bit("fill_valid", fill_valid, 1'b0);
endtask

task automatic out_of_order_test();
  mshr_pkg::addr_t a [4];
  mshr_pkg::line_t d [4];
  mshr_pkg::line_t l [4];
  for (int i = 0; i < 4; i++) begin
    a[i] = $urandom;
    d[i] = random_line();
    l[i] = random_line();
  end
  send_misses(2'b11, a[0], d[0], mshr_pkg::BUS_LOAD, a[1], d[1], mshr_pkg::BUS_LOAD);
  send_misses(2'b11, a[2], d[2], mshr_pkg::BUS_LOAD, a[3], d[3], mshr_pkg::BUS_LOAD);
  for (int i = 0; i < 4; i++) begin
    grant_request(mshr_pkg::BUS_LOAD, a[i], d[i], mshr_pkg::mem_tag_t'(i + 4), 0);
  end
  // nothing may fill while the oldest load is in flight
  for (int i = 3; i > 0; i--) begin
    return_line(mshr_pkg::mem_tag_t'(i + 4), l[i]);
    compare_bit("fill_valid", fill_valid, 1'b0);
  end
  return_line(4'h4, l[0]);
  for (int i = 0; i < 4; i++) begin
    expect_fill(a[i], l[i], (i == 0) ? 3 : 1);
  end
  wait_empty();
endtask

task automatic lookup_test();
  mshr_pkg::addr_t a0;
  mshr_pkg::addr_t a1;
  mshr_pkg::line_t l0;
  mshr_pkg::line_t l1;
  a0 = $urandom;
  a1 = $urandom;
  l0 = random_line();
  l1 = random_line();
  send_misses(2'b11, a0, '0, mshr_pkg::BUS_LOAD, a1, '0, mshr_pkg::BUS_LOAD);
  probe_lookup(a0, 1'b1);
  probe_lookup(a1, 1'b1);
  probe_lookup(a0 ^ a1 ^ 32'h5a5a_0001, 1'b0);
  grant_request(mshr_pkg::BUS_LOAD, a0, '0, 4'h2, 0);
  grant_request(mshr_pkg::BUS_LOAD, a1, '0, 4'h9, 0);
  return_line(4'h2, l0);
  expect_fill(a0, l0, 0);
  probe_lookup(a0, 1'b0);
  probe_lookup(a1, 1'b1);
  return_line(4'h9, l1);
  expect_fill(a1, l1, 0);
  wait_empty();
  probe_lookup(a1, 1'b0);
endtask

`endif

//--- testbench/tb_mshr.sv
`timescale 1ns/10ps

`include "mshr_params.svh"

module tb_mshr;

  localparam int WAIT_LIMIT = 200;

  logic                                 clock;
  logic                                 reset;
  logic [`MISS_LANES-1:0]               miss_valid;
  mshr_pkg::addr_t [`MISS_LANES-1:0]    miss_addr;
  mshr_pkg::line_t [`MISS_LANES-1:0]    miss_data;
  mshr_pkg::bus_cmd_t [`MISS_LANES-1:0] miss_cmd;
  logic                                 alloc_ready;
  logic                                 mshr_empty;
  mshr_pkg::addr_t                      search_addr;
  logic                                 search_hit;
  mshr_pkg::bus_cmd_t                   proc2mem_command;
  mshr_pkg::addr_t                      proc2mem_addr;
  mshr_pkg::line_t                      proc2mem_data;
  mshr_pkg::mem_tag_t                   mem2proc_response;
  mshr_pkg::mem_tag_t                   mem2proc_tag;
  mshr_pkg::line_t                      mem2proc_data;
  logic                                 fill_valid;
  mshr_pkg::addr_t                      fill_addr;
  mshr_pkg::line_t                      fill_data;
  logic                                 fill_ack;

  int unsigned seed;

  mshr_top UUT (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t waiting for %s", $time, what);
    stop_run();
  endtask

  task automatic compare_cmd(input string what, input mshr_pkg::bus_cmd_t got,
                             input mshr_pkg::bus_cmd_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      stop_run();
    end
  endtask

  task automatic compare_addr(input string what, input mshr_pkg::addr_t got,
                              input mshr_pkg::addr_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_line(input string what, input mshr_pkg::line_t got,
                              input mshr_pkg::line_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // each wait starts and ends on a falling edge
  task automatic wait_alloc_ready();
    int cycles;
    cycles = 0;
    while (alloc_ready !== 1'b1) begin
      if (cycles == WAIT_LIMIT) report_timeout("alloc_ready");
      cycles++;
      @(negedge clock);
    end
  endtask

  task automatic wait_command();
    int cycles;
    cycles = 0;
    while (proc2mem_command === mshr_pkg::BUS_NONE) begin
      if (cycles == WAIT_LIMIT) report_timeout("a memory request");
      cycles++;
      @(negedge clock);
    end
  endtask

  task automatic wait_fill();
    int cycles;
    cycles = 0;
    while (fill_valid !== 1'b1) begin
      if (cycles == WAIT_LIMIT) report_timeout("fill_valid");
      cycles++;
      @(negedge clock);
    end
  endtask

  task automatic wait_empty();
    int cycles;
    cycles = 0;
    while (mshr_empty !== 1'b1) begin
      if (cycles == WAIT_LIMIT) report_timeout("mshr_empty");
      cycles++;
      @(negedge clock);
    end
  endtask

  `include "mshr_tests.svh"

  initial begin
    seed = 32'h0070_9836;
    void'($urandom(seed));
    reset             = 1'b1;
    miss_valid        = '0;
    miss_addr         = '0;
    miss_data         = '0;
    miss_cmd          = {`MISS_LANES{mshr_pkg::BUS_NONE}};
    search_addr       = '0;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    fill_ack          = 1'b0;
    repeat (8) @(negedge clock);
    reset = 1'b0;

    check_reset_state();
    single_load_test();
    lane_order_test();
    eviction_test();
    out_of_order_test();
    lookup_test();

    $display("test passed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+common
+incdir+testbench
common/mshr_pkg.sv
common/mshr_entry_if.sv
design/mshr_alloc.sv
design/mshr_entry.sv
design/mshr_dispatch.sv
design/mshr_top.sv
testbench/tb_mshr.sv

//--- Bender.yml
package:
  name: mshr

sources:
  - include_dirs:
      - common
    files:
      - common/mshr_pkg.sv
      - common/mshr_entry_if.sv
      - design/mshr_alloc.sv
      - design/mshr_entry.sv
      - design/mshr_dispatch.sv
      - design/mshr_top.sv

  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_mshr.sv
